//--- rtl/mc_params.svh
`ifndef MC_PARAMS_SVH
`define MC_PARAMS_SVH

// tiles in the single row, must be a power of two
`define MC_NUM_TILES 4
// tile coordinate bits
`define MC_TILE_X_W ($clog2(`MC_NUM_TILES))

// per tile data memory
`define MC_DMEM_WORDS 16
`define MC_WORD_IDX_W 4

// payload and load tag widths
`define MC_DATA_W 32
`define MC_LOAD_ID_W 4

// fifo depth at each link receiver, also the credit counter reset value
`define MC_LINK_CREDITS 2

`endif

//--- rtl/mc_pkg.sv
`default_nettype none

`include "mc_params.svh"

package mc_pkg;

  typedef enum logic {
    MC_KIND_REQ  = 1'b0,
    MC_KIND_RESP = 1'b1
  } mc_kind_e;

  typedef enum logic {
    MC_OP_LOAD  = 1'b0,
    MC_OP_STORE = 1'b1
  } mc_op_e;

  // request view, kind sits in the top bit
  typedef struct packed {
    mc_kind_e                  kind;
    mc_op_e                    op;
    logic [`MC_LOAD_ID_W-1:0]  load_id;
    logic [`MC_TILE_X_W-1:0]   tile_x;
    logic [`MC_WORD_IDX_W-1:0] word_idx;
    logic [`MC_DATA_W-1:0]     data;
  } mc_req_s;

  // response view, padded out to the request width
  typedef struct packed {
    mc_kind_e                                   kind;
    logic [`MC_LOAD_ID_W-1:0]                   load_id;
    logic [`MC_TILE_X_W+`MC_WORD_IDX_W:0]       pad;
    logic [`MC_DATA_W-1:0]                      data;
  } mc_resp_s;

  // one link word, receiver picks the view from the shared kind bit
  typedef union packed {
    mc_req_s  req;
    mc_resp_s resp;
  } mc_link_word_u;

  // credit counters hold 0 .. MC_LINK_CREDITS
  localparam int MC_CREDIT_W = $clog2(`MC_LINK_CREDITS + 1);
  typedef logic [MC_CREDIT_W-1:0] mc_credit_t;

  // spend one on a send, gain one on a return, both cancel out
  function automatic mc_credit_t mc_credit_next(mc_credit_t cnt, logic spend, logic ret);
    mc_credit_t nxt;
    nxt = cnt;
    if (spend && !ret)
    begin
      nxt = cnt - 1'b1;
    end
    else if (ret && !spend)
    begin
      nxt = cnt + 1'b1;
    end
    return nxt;
  endfunction

endpackage

`default_nettype wire

//--- rtl/mc_host_injector.sv
`default_nettype none

`include "mc_params.svh"

module mc_host_injector (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // host request stream
  input  logic                                    req_valid_i,
  input  mc_pkg::mc_op_e                          req_op_i,
  input  logic [`MC_LOAD_ID_W-1:0]                req_load_id_i,
  input  logic [`MC_TILE_X_W+`MC_WORD_IDX_W-1:0]  req_addr_i,
  input  logic [`MC_DATA_W-1:0]                   req_data_i,
  output logic                                    req_ready_o,
  // link toward tile 0
  output logic                                    link_valid_o,
  output mc_pkg::mc_link_word_u                   link_word_o,
  input  logic                                    link_credit_i
);

  import mc_pkg::*;

  mc_credit_t credit_cnt_q;
  logic       send;
  mc_req_s    req_view;

  // ready tracks the credits for tile 0's fifo, no extra buffering here
  assign req_ready_o  = (credit_cnt_q != '0);
  assign send         = req_valid_i && req_ready_o;
  assign link_valid_o = send;

  // --------------------------------------------------------------------------
  // link word, built straight from the host inputs
  // --------------------------------------------------------------------------

  always_comb
  begin
    req_view.kind    = MC_KIND_REQ;
    req_view.op      = req_op_i;
    req_view.load_id = req_load_id_i;
    // tile x in the high address bits, word index below
    {req_view.tile_x, req_view.word_idx} = req_addr_i;
    req_view.data    = req_data_i;
  end

  assign link_word_o.req = req_view;

  // --------------------------------------------------------------------------
  // credit counter
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      credit_cnt_q <= mc_credit_t'(`MC_LINK_CREDITS);
    end
    else
    begin
      credit_cnt_q <= mc_credit_next(credit_cnt_q, send, link_credit_i);
    end
  end

endmodule

`default_nettype wire

//--- rtl/mc_tile.sv
`default_nettype none

`include "mc_params.svh"

module mc_tile (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // own coordinate from the generate index
  input  logic [`MC_TILE_X_W-1:0]   my_x_i,
  // link from the west
  input  logic                      in_valid_i,
  input  mc_pkg::mc_link_word_u     in_word_i,
  output logic                      in_credit_o,
  // link to the east
  output logic                      out_valid_o,
  output mc_pkg::mc_link_word_u     out_word_o,
  input  logic                      out_credit_i
);

  import mc_pkg::*;

  localparam int DEPTH = `MC_LINK_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  mc_link_word_u           fifo_mem [DEPTH];
  logic [PTR_W-1:0]        wr_ptr_q;
  logic [PTR_W-1:0]        rd_ptr_q;
  mc_credit_t              fifo_cnt_q;
  logic [`MC_DATA_W-1:0]   dmem_q [`MC_DMEM_WORDS];
  logic                    slot_valid_q;
  mc_link_word_u           slot_word_q;
  mc_credit_t              credit_cnt_q;
  mc_link_word_u           head;
  mc_resp_s                resp_view;
  logic                    pop;
  logic                    is_local;
  logic                    do_store;

  // --------------------------------------------------------------------------
  // input fifo
  // --------------------------------------------------------------------------

  // upstream only sends with a credit in hand, so no full check is needed
  always_ff @(posedge clk_i)
  begin
    if (in_valid_i)
    begin
      fifo_mem[wr_ptr_q] <= in_word_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end
    else
    begin
      if (in_valid_i)
      begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop)
      begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fifo_cnt_q <= mc_credit_next(fifo_cnt_q, pop, in_valid_i);
    end
  end

  assign head = fifo_mem[rd_ptr_q];
  // one packet in flight, head waits for an empty slot
  assign pop         = (fifo_cnt_q != '0) && !slot_valid_q;
  // each pop frees a fifo entry, hand the credit back west
  assign in_credit_o = pop;

  // --------------------------------------------------------------------------
  // address match and data memory
  // --------------------------------------------------------------------------

  // responses and foreign requests just pass through
  assign is_local = (head.req.kind == MC_KIND_REQ) && (head.req.tile_x == my_x_i);
  assign do_store = pop && is_local && (head.req.op == MC_OP_STORE);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < `MC_DMEM_WORDS; i++)
      begin
        dmem_q[i] <= '0;
      end
    end
    else if (do_store)
    begin
      dmem_q[head.req.word_idx] <= head.req.data;
    end
  end

  // load reply, read on the pop cycle
  always_comb
  begin
    resp_view.kind    = MC_KIND_RESP;
    resp_view.load_id = head.req.load_id;
    resp_view.pad     = '0;
    resp_view.data    = dmem_q[head.req.word_idx];
  end

  // --------------------------------------------------------------------------
  // output slot and credit counter
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i)
  begin
    if (pop)
    begin
      slot_word_q <= is_local ? mc_link_word_u'(resp_view) : head;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      slot_valid_q <= 1'b0;
      credit_cnt_q <= mc_credit_t'(`MC_LINK_CREDITS);
    end
    else
    begin
      // stores end here, everything else takes the slot
      if (pop && !do_store)
      begin
        slot_valid_q <= 1'b1;
      end
      else if (out_valid_o)
      begin
        slot_valid_q <= 1'b0;
      end
      credit_cnt_q <= mc_credit_next(credit_cnt_q, out_valid_o, out_credit_i);
    end
  end

  // slot leaves as soon as the next hop has room
  assign out_valid_o = slot_valid_q && (credit_cnt_q != '0);
  assign out_word_o  = slot_word_q;

endmodule

`default_nettype wire

//--- rtl/mc_resp_collector.sv
`default_nettype none

`include "mc_params.svh"

module mc_resp_collector (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // link from the last tile
  input  logic                      in_valid_i,
  input  mc_pkg::mc_link_word_u     in_word_i,
  output logic                      in_credit_o,
  // host response stream
  output logic                      resp_valid_o,
  output logic [`MC_LOAD_ID_W-1:0]  resp_load_id_o,
  output logic [`MC_DATA_W-1:0]     resp_data_o,
  input  logic                      resp_ready_i
);

  import mc_pkg::*;

  localparam int DEPTH = `MC_LINK_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  mc_link_word_u     fifo_mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  mc_credit_t        fifo_cnt_q;
  mc_resp_s          head;
  logic              pop;

  // --------------------------------------------------------------------------
  // egress fifo
  // --------------------------------------------------------------------------

  // sender holds a credit for every word, fifo never overflows
  always_ff @(posedge clk_i)
  begin
    if (in_valid_i)
    begin
      fifo_mem[wr_ptr_q] <= in_word_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end
    else
    begin
      if (in_valid_i)
      begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop)
      begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fifo_cnt_q <= mc_credit_next(fifo_cnt_q, pop, in_valid_i);
    end
  end

  // only responses reach the east end
  assign head = fifo_mem[rd_ptr_q].resp;

  // head stays put until the host takes it
  assign resp_valid_o   = (fifo_cnt_q != '0);
  assign resp_load_id_o = head.load_id;
  assign resp_data_o    = head.data;

  assign pop         = resp_valid_o && resp_ready_i;
  assign in_credit_o = pop;

endmodule

`default_nettype wire

//--- rtl/mc_array.sv
`default_nettype none

`include "mc_params.svh"

module mc_array (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // host ingress
  input  logic                                    req_valid_i,
  input  mc_pkg::mc_op_e                          req_op_i,
  input  logic [`MC_LOAD_ID_W-1:0]                req_load_id_i,
  input  logic [`MC_TILE_X_W+`MC_WORD_IDX_W-1:0]  req_addr_i,
  input  logic [`MC_DATA_W-1:0]                   req_data_i,
  output logic                                    req_ready_o,
  // host egress
  output logic                                    resp_valid_o,
  output logic [`MC_LOAD_ID_W-1:0]                resp_load_id_o,
  output logic [`MC_DATA_W-1:0]                   resp_data_o,
  input  logic                                    resp_ready_i
);

  import mc_pkg::*;

  localparam int TILE_X_W = `MC_TILE_X_W;

  // hop 0 is injector to tile 0, hop k feeds tile k, last hop feeds the collector
  logic [`MC_NUM_TILES:0]  link_valid;
  mc_link_word_u           link_word [`MC_NUM_TILES+1];
  logic [`MC_NUM_TILES:0]  link_credit;

  mc_host_injector i_injector (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_op_i      (req_op_i),
    .req_load_id_i (req_load_id_i),
    .req_addr_i    (req_addr_i),
    .req_data_i    (req_data_i),
    .req_ready_o   (req_ready_o),
    .link_valid_o  (link_valid[0]),
    .link_word_o   (link_word[0]),
    .link_credit_i (link_credit[0])
  );

  // --------------------------------------------------------------------------
  // tile chain, west to east
  // --------------------------------------------------------------------------

  for (genvar g = 0; g < `MC_NUM_TILES; g++)
  begin : g_tile
    mc_tile i_tile (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .my_x_i       (TILE_X_W'(g)),
      .in_valid_i   (link_valid[g]),
      .in_word_i    (link_word[g]),
      .in_credit_o  (link_credit[g]),
      .out_valid_o  (link_valid[g+1]),
      .out_word_o   (link_word[g+1]),
      .out_credit_i (link_credit[g+1])
    );
  end

  mc_resp_collector i_collector (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .in_valid_i     (link_valid[`MC_NUM_TILES]),
    .in_word_i      (link_word[`MC_NUM_TILES]),
    .in_credit_o    (link_credit[`MC_NUM_TILES]),
    .resp_valid_o   (resp_valid_o),
    .resp_load_id_o (resp_load_id_o),
    .resp_data_o    (resp_data_o),
    .resp_ready_i   (resp_ready_i)
  );

endmodule

`default_nettype wire

//--- test/mc_array_chk.sv
`default_nettype none

`include "mc_params.svh"

module mc_array_chk (
  input logic                    clk_i,
  input logic                    rst_n_i,
  // every hop of the chain, injector link first
  input logic [`MC_NUM_TILES:0]  link_valid_i,
  input logic [`MC_NUM_TILES:0]  link_credit_i,
  // host egress
  input logic                    resp_valid_i,
  input logic [`MC_DATA_W-1:0]   resp_data_i,
  input logic                    resp_ready_i
);

  import mc_pkg::*;

  localparam int HOPS = `MC_NUM_TILES + 1;

  // sender view of each hop, rebuilt from sends and returned credits
  int               credit_q [HOPS];
  logic [HOPS-1:0]  spend_dry;
  logic [HOPS-1:0]  over_limit;
  // one tally per property
  int               credit_fails = 0;
  int               bound_fails = 0;
  int               stable_fails = 0;
  int               fail_cnt;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int h = 0; h < HOPS; h++)
      begin
        credit_q[h] <= `MC_LINK_CREDITS;
      end
    end
    else
    begin
      // send costs one, a returned pulse gives one back
      for (int h = 0; h < HOPS; h++)
      begin
        credit_q[h] <= credit_q[h] - int'(link_valid_i[h]) + int'(link_credit_i[h]);
      end
    end
  end

  always_comb
  begin
    for (int h = 0; h < HOPS; h++)
    begin
      spend_dry[h]  = link_valid_i[h] && (credit_q[h] <= 0);
      over_limit[h] = (credit_q[h] > `MC_LINK_CREDITS);
    end
  end

  assign fail_cnt = credit_fails + bound_fails + stable_fails;

  // --------------------------------------------------------------------------
  // link and egress properties
  // --------------------------------------------------------------------------

  a_valid_needs_credit : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    spend_dry == '0)
  else
  begin
    $error("link valid with no credit left, hops %b", spend_dry);
    credit_fails++;
  end

  a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    over_limit == '0)
  else
  begin
    $error("credit count above fifo depth, hops %b", over_limit);
    bound_fails++;
  end

  // stalled egress keeps its word
  a_resp_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_data_i))
  else
  begin
    $error("egress word changed or dropped while stalled");
    stable_fails++;
  end

endmodule

bind mc_array mc_array_chk i_chk (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .link_valid_i  (link_valid),
  .link_credit_i (link_credit),
  .resp_valid_i  (resp_valid_o),
  .resp_data_i   (resp_data_o),
  .resp_ready_i  (resp_ready_i)
);

`default_nettype wire

//--- test/mc_array_monitor.sv
`default_nettype none

`include "mc_params.svh"

module mc_array_monitor (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // host ingress as seen at the DUT ports
  input  logic                                    req_valid_i,
  input  mc_pkg::mc_op_e                          req_op_i,
  input  logic [`MC_LOAD_ID_W-1:0]                req_load_id_i,
  input  logic [`MC_TILE_X_W+`MC_WORD_IDX_W-1:0]  req_addr_i,
  input  logic [`MC_DATA_W-1:0]                   req_data_i,
  input  logic                                    req_ready_i,
  // host egress
  input  logic                                    resp_valid_i,
  input  logic [`MC_LOAD_ID_W-1:0]                resp_load_id_i,
  input  logic [`MC_DATA_W-1:0]                   resp_data_i,
  input  logic                                    resp_ready_i,
  // running totals for the testbench
  output int                                      err_cnt_o,
  output int                                      resp_cnt_o,
  output int                                      pending_o
);

  import mc_pkg::*;

  localparam int ADDRS = `MC_NUM_TILES * `MC_DMEM_WORDS;

  // every tile memory side by side, indexed by host address
  logic [`MC_DATA_W-1:0]     ref_mem [ADDRS];
  // responses still owed, oldest at the front
  logic [`MC_LOAD_ID_W-1:0]  exp_id_q [$];
  logic [`MC_DATA_W-1:0]     exp_data_q [$];
  logic [`MC_LOAD_ID_W-1:0]  exp_id;
  logic [`MC_DATA_W-1:0]     exp_data;
  int                        err_cnt = 0;
  int                        resp_cnt = 0;
  int                        pending = 0;

  always @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      // tile memories come out of reset cleared
      for (int a = 0; a < ADDRS; a++)
      begin
        ref_mem[a] = '0;
      end
      exp_id_q.delete();
      exp_data_q.delete();
      pending = 0;
    end
    else
    begin
      // egress side first, a request taken now cannot answer on this edge
      if (resp_valid_i && resp_ready_i)
      begin
        if (pending == 0)
        begin
          $display("error at %0t: response with load id %0h arrived while no load was waiting",
                   $time, resp_load_id_i);
          err_cnt++;
        end
        else
        begin
          exp_id   = exp_id_q.pop_front();
          exp_data = exp_data_q.pop_front();
          pending--;
          if (resp_load_id_i !== exp_id)
          begin
            $display("mismatch at %0t: resp_load_id_o expected %0h got %0h",
                     $time, exp_id, resp_load_id_i);
            err_cnt++;
          end
          if (resp_data_i !== exp_data)
          begin
            $display("mismatch at %0t: resp_data_o expected %08h got %08h",
                     $time, exp_data, resp_data_i);
            err_cnt++;
          end
          resp_cnt++;
        end
      end
      // stores update the image, loads book the word they should return
      if (req_valid_i && req_ready_i)
      begin
        if (req_op_i == MC_OP_STORE)
        begin
          ref_mem[req_addr_i] = req_data_i;
        end
        else
        begin
          exp_id_q.push_back(req_load_id_i);
          exp_data_q.push_back(ref_mem[req_addr_i]);
          pending++;
        end
      end
    end
  end

  assign err_cnt_o  = err_cnt;
  assign resp_cnt_o = resp_cnt;
  assign pending_o  = pending;

endmodule

`default_nettype wire

//--- test/mc_array_tb.sv
`default_nettype none

`include "mc_params.svh"

module mc_array_tb;

  import mc_pkg::*;

  localparam int ADDR_W           = `MC_TILE_X_W + `MC_WORD_IDX_W;
  localparam int WORDS            = `MC_DMEM_WORDS;
  localparam int TILES            = `MC_NUM_TILES;
  localparam int CYCLES_PER_ENTRY = 40;
  localparam int HOLD_CYCLES      = 60;
  localparam int GRP_BACKPRESSURE = 5;

  // one table row, hold is the number of cycles resp_ready stays low
  typedef struct packed {
    logic [2:0]                group;
    mc_op_e                    op;
    logic [`MC_LOAD_ID_W-1:0]  load_id;
    logic [ADDR_W-1:0]         addr;
    logic [`MC_DATA_W-1:0]     data;
    logic                      rnd;
    logic [7:0]                hold;
  } stim_t;

  logic                       clk_i;
  logic                       rst_n_i;
  logic                       req_valid;
  mc_op_e                     req_op;
  logic [`MC_LOAD_ID_W-1:0]   req_load_id;
  logic [ADDR_W-1:0]          req_addr;
  logic [`MC_DATA_W-1:0]      req_data;
  logic                       req_ready;
  logic                       resp_valid;
  logic [`MC_LOAD_ID_W-1:0]   resp_load_id;
  logic [`MC_DATA_W-1:0]      resp_data;
  logic                       resp_ready;
  int                         err_cnt;
  int                         resp_cnt;
  int                         pending;
  stim_t                      stim_q [$];
  logic                       table_ready = 1'b0;
  integer                     seed;
  int                         tb_fails = 0;
  int                         sent = 0;
  int                         grp_resp0 = 0;
  int                         grp_err0 = 0;

  mc_array i_dut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid),
    .req_op_i       (req_op),
    .req_load_id_i  (req_load_id),
    .req_addr_i     (req_addr),
    .req_data_i     (req_data),
    .req_ready_o    (req_ready),
    .resp_valid_o   (resp_valid),
    .resp_load_id_o (resp_load_id),
    .resp_data_o    (resp_data),
    .resp_ready_i   (resp_ready)
  );

  mc_array_monitor i_monitor (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_valid_i     (req_valid),
    .req_op_i        (req_op),
    .req_load_id_i   (req_load_id),
    .req_addr_i      (req_addr),
    .req_data_i      (req_data),
    .req_ready_i     (req_ready),
    .resp_valid_i    (resp_valid),
    .resp_load_id_i  (resp_load_id),
    .resp_data_i     (resp_data),
    .resp_ready_i    (resp_ready),
    .err_cnt_o       (err_cnt),
    .resp_cnt_o      (resp_cnt),
    .pending_o       (pending)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // stimulus table
  // --------------------------------------------------------------------------

  task automatic add_entry(input int grp, input mc_op_e op, input int id, input int addr,
                           input logic [`MC_DATA_W-1:0] data, input bit rnd, input int hold);
    stim_t e;
    e.group   = grp[2:0];
    e.op      = op;
    e.load_id = id[`MC_LOAD_ID_W-1:0];
    e.addr    = addr[ADDR_W-1:0];
    e.data    = data;
    e.rnd     = rnd;
    e.hold    = hold[7:0];
    stim_q.push_back(e);
  endtask

  task automatic build_table();
    int a;
    int t;
    // every word of every tile, straight after reset
    for (a = 0; a < TILES * WORDS; a++)
    begin
      add_entry(1, MC_OP_LOAD, a, a, '0, 1'b0, 0);
    end
    // random store then read back, one word per tile
    for (t = 0; t < TILES; t++)
    begin
      a = t * WORDS + (t * 3 + 1) % WORDS;
      add_entry(2, MC_OP_STORE, 0, a, '0, 1'b1, 0);
      add_entry(2, MC_OP_LOAD, t, a, '0, 1'b0, 0);
    end
    // word 9 in every tile, each must keep its own value
    for (t = 0; t < TILES; t++)
    begin
      add_entry(3, MC_OP_STORE, 0, t * WORDS + 9, 32'h5a00_0000 + t, 1'b0, 0);
    end
    for (t = 0; t < TILES; t++)
    begin
      add_entry(3, MC_OP_LOAD, t + 8, t * WORDS + 9, '0, 1'b0, 0);
    end
    // tiles in mixed order, nonzero words from groups 2 and 3
    for (int i = 0; i < 8; i++)
    begin
      t = (i * 3 + 1) % TILES;
      a = t * WORDS + ((i < 4) ? 9 : (t * 3 + 1) % WORDS);
      add_entry(4, MC_OP_LOAD, i, a, '0, 1'b0, 0);
    end
    // more loads than the chain can buffer while egress is stalled
    for (int i = 0; i < 16; i++)
    begin
      a = (i % TILES) * WORDS + (i * 7) % WORDS;
      add_entry(GRP_BACKPRESSURE, MC_OP_LOAD, i, a, '0, 1'b0, (i == 0) ? HOLD_CYCLES : 0);
    end
  endtask

  function automatic string group_name(input int grp);
    case (grp)
      1: return "memories clear after reset";
      2: return "store then load per tile";
      3: return "same word index in separate tiles";
      4: return "mixed tile order";
      5: return "egress back-pressure";
      default: return "unknown";
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // drivers
  // --------------------------------------------------------------------------

  // by the end of the stall every hop is full back to the injector
  task automatic hold_resp_ready(input int cycles);
    resp_ready <= 1'b0;
    repeat (cycles) @(posedge clk_i);
    if (req_ready)
    begin
      $display("failure: req_ready_o still high after egress was held for %0d cycles",
               cycles);
      tb_fails++;
    end
    resp_ready <= 1'b1;
  endtask

  // called on a rising edge, returns on the edge where the request is taken
  task automatic apply_entry(input stim_t e);
    logic [`MC_DATA_W-1:0] d;
    int                    hold_n;
    d = e.data;
    if (e.rnd)
    begin
      d = $random(seed);
    end
    if (e.hold != '0)
    begin
      hold_n = int'(e.hold);
      fork
        hold_resp_ready(hold_n);
      join_none
    end
    req_valid   <= 1'b1;
    req_op      <= e.op;
    req_load_id <= e.load_id;
    req_addr    <= e.addr;
    req_data    <= d;
    @(posedge clk_i);
    while (!req_ready)
    begin
      @(posedge clk_i);
    end
    sent++;
  endtask

  // drain the group, totals are read mid cycle where they are settled
  task automatic finish_group(input int grp);
    int errs;
    req_valid <= 1'b0;
    @(negedge clk_i);
    while (pending != 0)
    begin
      @(negedge clk_i);
    end
    errs = err_cnt + tb_fails - grp_err0;
    $display("group %0d (%s): %0d responses, %0d errors", grp, group_name(grp),
             resp_cnt - grp_resp0, errs);
    grp_resp0 = resp_cnt;
    grp_err0  = err_cnt + tb_fails;
    @(posedge clk_i);
  endtask

  initial
  begin : main_seq
    int total_fails;
    rst_n_i     = 1'b0;
    req_valid   = 1'b0;
    req_op      = MC_OP_LOAD;
    req_load_id = '0;
    req_addr    = '0;
    req_data    = '0;
    resp_ready  = 1'b1;
    seed        = 32'hc5c3677c;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    for (int i = 0; i < stim_q.size(); i++)
    begin
      apply_entry(stim_q[i]);
      if ((i == stim_q.size() - 1) || (stim_q[i+1].group != stim_q[i].group))
      begin
        finish_group(int'(stim_q[i].group));
      end
    end
    total_fails = err_cnt + tb_fails + i_dut.i_chk.fail_cnt;
    $display("summary: %0d requests, %0d responses, %0d monitor errors, %0d other, %0d assertion",
             sent, resp_cnt, err_cnt, tb_fails, i_dut.i_chk.fail_cnt);
    if (total_fails == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog, budget scales with the table
  initial
  begin
    wait (table_ready);
    repeat (stim_q.size() * CYCLES_PER_ENTRY) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", stim_q.size() * CYCLES_PER_ENTRY);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
rtl/mc_pkg.sv
rtl/mc_host_injector.sv
rtl/mc_tile.sv
rtl/mc_resp_collector.sv
rtl/mc_array.sv
test/mc_array_chk.sv
test/mc_array_monitor.sv
test/mc_array_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module mc_array_tb -f files.f || exit 1
out="$(./obj_dir/Vmc_array_tb +verilator+error+limit+1000)"
echo "$out"
echo "$out" | grep -q "STATUS: PASS" && exit 0 || exit 1
